// File: sources.f
+incdir+tb
common/vmul_pkg.sv
rtl/vmul_stage.sv
vmul/vmul_operand_prep.sv
vmul/vmul_lane.sv
vmul/vmul_result_sel.sv
vmul/vmul_top.sv
tb/tb_vmul.sv

// File: run_sim.sh
#!/bin/sh
# build and run the vmul testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=build/obj

mkdir -p "$OBJ"
if [ $? -ne 0 ]; then
    echo "cannot create $OBJ"
    exit 1
fi

verilator --binary --timing -Wno-fatal --top-module tb_vmul \
    -f sources.f -Mdir "$OBJ" -o vtb_vmul
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$OBJ/vtb_vmul" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^sim passed$' "$LOG"; then
    exit 0
fi
exit 1

// File: tb/vmul_ref.svh
//////////////////////////////////////////////////////////////////////
// vmul reference model
// expected result and byte mask of one input transaction
//////////////////////////////////////////////////////////////////////

`ifndef VMUL_REF_SVH
`define VMUL_REF_SVH

// numeric value of one element, sign or zero extended
function automatic longint elem_value(input logic [15:0] bits, input int w, input logic sgn);
    longint v;
    if (w == 8) begin
        v = sgn ? longint'($signed(bits[7:0])) : longint'(bits[7:0]);
    end else begin
        v = sgn ? longint'($signed(bits)) : longint'(bits);
    end
    return v;
endfunction

function automatic vmul_out_t vmul_ref(input vmul_in_t t);
    vmul_out_t   r;
    int          w;
    int          n;
    longint      a;
    longint      b;
    longint      p;
    longint      acc;
    logic [63:0] pv;
    logic [7:0]  vl_bytes;
    r.ctrl = t.ctrl;
    r.res  = '0;
    w = (t.ctrl.eew == EEW_16) ? 16 : 8;
    n = 64 / w;
    for (int e = 0; e < n; e++) begin
        a = elem_value(16'(t.op1 >> (w*e)), w, t.ctrl.op1_signed);
        b = elem_value(16'(t.op2 >> (w*e)), w, t.ctrl.op2_signed);
        p = a * b;
        // accumulator element is always taken as signed
        if (t.ctrl.op == MUL_VMACC) begin
            acc = elem_value(16'(t.op3 >> (w*e)), w, 1'b1);
            p   = t.ctrl.accsub ? acc - p : acc + p;
        end
        pv = 64'(p);
        if (t.ctrl.op == MUL_VMULH) begin
            pv = pv >> w;
        end
        if (w == 8) begin
            r.res[8*e +: 8] = pv[7:0];
        end else begin
            r.res[16*e +: 16] = pv[15:0];
        end
    end
    // bytes up to the last active one, then the element mask on top
    vl_bytes = t.ctrl.vl_part_0 ? 8'h00 : (8'hff >> (3'd7 - t.ctrl.vl_part));
    r.mask   = t.ctrl.masked ? (t.mask & vl_bytes) : vl_bytes;
    return r;
endfunction

`endif

// File: tb/tb_vmul.sv
//////////////////////////////////////////////////////////////////////
// vmul testbench
// random and edge stimulus with a scoreboard against a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_vmul;

    import vmul_pkg::*;

    `include "vmul_ref.svh"

    localparam logic [31:0] SEED = 32'h75157fbf;
    // about 600 transactions at half output rate need some 1200 cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk_i;
    logic      async_rst_ni;
    logic      in_valid_i;
    logic      in_ready_o;
    vmul_in_t  in_data_i;
    logic      out_valid_o;
    logic      out_ready_i;
    vmul_out_t out_data_o;

    vmul_out_t   exp_q[$];
    vmul_out_t   exp_item;
    logic [31:0] stim_rng;
    logic [31:0] rdy_rng;
    logic [7:0]  next_tag;
    logic        bp_en;
    int          cycle_cnt = 0;
    int          res_errs = 0;
    int          mask_errs = 0;
    int          ctrl_errs = 0;
    int          other_errs = 0;

    vmul_top i_vmul_top (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_data_i    (in_data_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_data_o   (out_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // random numbers and transaction builders

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    function automatic vmul_in_t make_txn(input vmul_op_e op, input vmul_eew_e eew,
                                          input logic [1:0] sgn, input logic accsub);
        vmul_in_t    t;
        logic [31:0] r;
        t = '0;
        t.ctrl.op         = op;
        t.ctrl.eew        = eew;
        t.ctrl.op1_signed = sgn[1];
        t.ctrl.op2_signed = sgn[0];
        t.ctrl.accsub     = accsub;
        t.ctrl.vl_part    = 3'd7;
        t.op1 = {next_rand(), next_rand()};
        t.op2 = {next_rand(), next_rand()};
        t.op3 = {next_rand(), next_rand()};
        r = next_rand();
        t.mask = r[7:0];
        return t;
    endfunction

    // operand built from the extreme element values
    function automatic logic [63:0] edge_operand(input vmul_eew_e eew);
        logic [63:0] v;
        logic [31:0] r;
        v = '0;
        r = next_rand();
        for (int e = 0; e < 8; e++) begin
            case (r[2*e +: 2])
                2'd0:    v[8*e +: 8] = 8'h80;
                2'd1:    v[8*e +: 8] = 8'hff;
                2'd2:    v[8*e +: 8] = 8'h7f;
                default: v[8*e +: 8] = 8'h01;
            endcase
        end
        if (eew == EEW_16) begin
            for (int k = 0; k < 4; k++) begin
                case (r[2*k+16 +: 2])
                    2'd0:    v[16*k +: 16] = 16'h8000;
                    2'd1:    v[16*k +: 16] = 16'hffff;
                    2'd2:    v[16*k +: 16] = 16'h7fff;
                    default: v[16*k +: 16] = 16'h0001;
                endcase
            end
        end
        return v;
    endfunction

    // any operation with random mask and vector length fields
    function automatic vmul_in_t random_txn();
        vmul_in_t    t;
        logic [31:0] r;
        vmul_op_e    op;
        r = next_rand();
        case (r % 3)
            0:       op = MUL_VMUL;
            1:       op = MUL_VMULH;
            default: op = MUL_VMACC;
        endcase
        t = make_txn(op, r[2] ? EEW_16 : EEW_8, r[4:3], r[5]);
        t.ctrl.masked    = r[6];
        t.ctrl.vl_part_0 = (r[9:7] == 3'd0);
        t.ctrl.vl_part   = r[12:10];
        t.mask           = r[20:13];
        return t;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // driving tasks

    task automatic send_txn(input vmul_in_t txn);
        vmul_in_t t;
        t = txn;
        t.ctrl.tag = next_tag;
        next_tag = next_tag + 8'd1;
        in_valid_i <= 1'b1;
        in_data_i  <= t;
        @(posedge clk_i);
        while (!in_ready_o) @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    // one lone operation, edges from acceptance to the output transfer
    task automatic measure_latency();
        int lat;
        send_txn(make_txn(MUL_VMUL, EEW_8, 2'b11, 1'b0));
        lat = 0;
        do begin
            @(posedge clk_i);
            lat++;
        end while (!out_valid_o);
        if (lat != 4) begin
            $display("output appeared %0d cycles after acceptance instead of 4", lat);
            other_errs++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 500) begin
            @(posedge clk_i);
            n++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks and scoreboard

    task automatic check_res(input logic [VMUL_OP_W-1:0] exp, input logic [VMUL_OP_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED res: expected %h, got %h", exp, act);
            res_errs++;
        end
    endtask

    task automatic check_mask(input logic [VMUL_BYTES-1:0] exp, input logic [VMUL_BYTES-1:0] act);
        if (act !== exp) begin
            $display("FAILED mask: expected %h, got %h", exp, act);
            mask_errs++;
        end
    endtask

    task automatic check_ctrl(input vmul_ctrl_t exp, input vmul_ctrl_t act);
        if (act !== exp) begin
            $display("FAILED ctrl: expected %h, got %h", exp, act);
            ctrl_errs++;
        end
    endtask

    always @(posedge clk_i) begin
        if (async_rst_ni) begin
            if (in_valid_i && in_ready_o) begin
                exp_q.push_back(vmul_ref(in_data_i));
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("output transfer with no matching input, tag %h",
                             out_data_o.ctrl.tag);
                    other_errs++;
                end else begin
                    exp_item = exp_q.pop_front();
                    check_res(exp_item.res, out_data_o.res);
                    check_mask(exp_item.mask, out_data_o.mask);
                    check_ctrl(exp_item.ctrl, out_data_o.ctrl);
                end
            end
        end
    end

    // output ready, random while back-pressure is on
    initial begin
        out_ready_i = 1'b1;
        rdy_rng = ~SEED;
        forever begin
            @(posedge clk_i);
            if (bp_en) begin
                rdy_rng = xorshift32(rdy_rng);
                out_ready_i <= rdy_rng[0];
            end else begin
                out_ready_i <= 1'b1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        vmul_eew_e eew;
        vmul_in_t  t;
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b0;
        in_data_i    = '0;
        bp_en        = 1'b0;
        stim_rng     = SEED;
        next_tag     = 8'd0;
        repeat (3) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(posedge clk_i);
        if (out_valid_o !== 1'b0) begin
            $display("out_valid_o is not low after reset");
            other_errs++;
        end
        if (in_ready_o !== 1'b1) begin
            $display("in_ready_o is not high after reset");
            other_errs++;
        end

        measure_latency();

        for (int e = 0; e < 2; e++) begin
            eew = (e == 1) ? EEW_16 : EEW_8;
            for (int s = 0; s < 4; s++) begin
                repeat (20) send_txn(make_txn(MUL_VMUL, eew, 2'(s), 1'b0));
                // high halves on extreme values
                repeat (8) begin
                    t = make_txn(MUL_VMULH, eew, 2'(s), 1'b0);
                    t.op1 = edge_operand(eew);
                    t.op2 = edge_operand(eew);
                    send_txn(t);
                end
                repeat (8) send_txn(make_txn(MUL_VMACC, eew, 2'(s), 1'b0));
                repeat (8) send_txn(make_txn(MUL_VMACC, eew, 2'(s), 1'b1));
            end
        end

        // mask and vector length
        repeat (100) send_txn(random_txn());
        repeat (4) begin
            t = random_txn();
            t.ctrl.vl_part_0 = 1'b1;
            send_txn(t);
        end

        // back-to-back under random back-pressure
        bp_en <= 1'b1;
        repeat (150) send_txn(random_txn());
        bp_en <= 1'b0;
        wait_drain();
        repeat (4) @(posedge clk_i);

        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            other_errs++;
        end
        $display("errors: res %0d, mask %0d, ctrl %0d, other %0d",
                 res_errs, mask_errs, ctrl_errs, other_errs);
        if (res_errs + mask_errs + ctrl_errs + other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: vmul/vmul_top.sv
//////////////////////////////////////////////////////////////////////
// SIMD multiplier top
// four-stage valid/ready pipeline around eight byte-lane multipliers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module vmul_top (
    input  logic                clk_i,
    input  logic                async_rst_ni,

    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  vmul_pkg::vmul_in_t  in_data_i,

    output logic                out_valid_o,
    input  logic                out_ready_i,
    output vmul_pkg::vmul_out_t out_data_o
);

    import vmul_pkg::*;

    // handshake between stages
    logic s1_valid, s2_valid, s3_valid;
    logic s2_ready, s3_ready, s4_ready;

    vmul_in_t    s1_data;
    vmul_lanes_t lanes_d, s2_data;
    vmul_prod_t  prod_d, s3_data;
    vmul_out_t   out_d;

    logic [VMUL_BYTES-1:0][VMUL_LANE_RES_W-1:0] lane_res;

    //////////////////////////////////////////////////////////////////////
    // stage 1: input register

    vmul_stage #(.T(vmul_in_t)) i_s1 (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (in_valid_i),
        .ready_o      (in_ready_o),
        .data_i       (in_data_i),
        .valid_o      (s1_valid),
        .ready_i      (s2_ready),
        .data_o       (s1_data)
    );

    vmul_operand_prep i_prep (
        .in_i    (s1_data),
        .lanes_o (lanes_d)
    );

    //////////////////////////////////////////////////////////////////////
    // stage 2: lane operands

    vmul_stage #(.T(vmul_lanes_t)) i_s2 (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (s1_valid),
        .ready_o      (s2_ready),
        .data_i       (lanes_d),
        .valid_o      (s2_valid),
        .ready_i      (s3_ready),
        .data_o       (s2_data)
    );

    for (genvar g = 0; g < VMUL_BYTES; g++) begin : gen_lane
        vmul_lane i_lane (
            .a_i       (s2_data.lane_a[g]),
            .b_i       (s2_data.lane_b[g]),
            .acc_i     (s2_data.lane_acc[g]),
            .acc_en_i  (s2_data.acc_en),
            .acc_sub_i (s2_data.acc_sub),
            .res_o     (lane_res[g])
        );
    end

    assign prod_d.ctrl     = s2_data.ctrl;
    assign prod_d.prod     = lane_res;
    assign prod_d.res_mask = s2_data.res_mask;

    //////////////////////////////////////////////////////////////////////
    // stage 3: lane products

    vmul_stage #(.T(vmul_prod_t)) i_s3 (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (s2_valid),
        .ready_o      (s3_ready),
        .data_i       (prod_d),
        .valid_o      (s3_valid),
        .ready_i      (s4_ready),
        .data_o       (s3_data)
    );

    vmul_result_sel i_sel (
        .prod_i (s3_data),
        .out_o  (out_d)
    );

    //////////////////////////////////////////////////////////////////////
    // stage 4: result register

    vmul_stage #(.T(vmul_out_t)) i_s4 (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (s3_valid),
        .ready_o      (s4_ready),
        .data_i       (out_d),
        .valid_o      (out_valid_o),
        .ready_i      (out_ready_i),
        .data_o       (out_data_o)
    );

endmodule

// File: vmul/vmul_result_sel.sv
//////////////////////////////////////////////////////////////////////
// result selection
// gathers the low or high product half of each element
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module vmul_result_sel (
    input  vmul_pkg::vmul_prod_t prod_i,
    output vmul_pkg::vmul_out_t  out_o
);

    import vmul_pkg::*;

    logic keep_high;

    // only VMULH keeps the upper half, VMACC uses the low half like VMUL
    assign keep_high = (prod_i.ctrl.op == MUL_VMULH);

    always_comb begin
        out_o.res = '0;
        if (prod_i.ctrl.eew == EEW_8) begin
            for (int i = 0; i < VMUL_BYTES; i++) begin
                if (keep_high) begin
                    out_o.res[8*i +: 8] = prod_i.prod[i][15:8];
                end else begin
                    out_o.res[8*i +: 8] = prod_i.prod[i][7:0];
                end
            end
        end else begin
            // halfword results live in the even lanes
            for (int k = 0; k < VMUL_BYTES/2; k++) begin
                if (keep_high) begin
                    out_o.res[16*k +: 16] = prod_i.prod[2*k][31:16];
                end else begin
                    out_o.res[16*k +: 16] = prod_i.prod[2*k][15:0];
                end
            end
        end
    end

    assign out_o.ctrl = prod_i.ctrl;
    assign out_o.mask = prod_i.res_mask;

endmodule

// File: vmul/vmul_lane.sv
//////////////////////////////////////////////////////////////////////
// multiplier lane
// signed 17x17 multiply with optional accumulate or subtract
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module vmul_lane (
    input  logic signed [vmul_pkg::VMUL_LANE_OP_W-1:0]  a_i,
    input  logic signed [vmul_pkg::VMUL_LANE_OP_W-1:0]  b_i,
    input  logic        [vmul_pkg::VMUL_LANE_RES_W-1:0] acc_i,
    input  logic                                        acc_en_i,
    input  logic                                        acc_sub_i,
    output logic        [vmul_pkg::VMUL_LANE_RES_W-1:0] res_o
);

    import vmul_pkg::*;

    logic signed [2*VMUL_LANE_OP_W-1:0] prod_full;
    logic        [VMUL_LANE_RES_W-1:0]  prod;

    // operands come from at most 16-bit elements, so 33 bits hold the product
    assign prod_full = a_i * b_i;
    assign prod      = prod_full[VMUL_LANE_RES_W-1:0];

    always_comb begin
        if (!acc_en_i) begin
            res_o = prod;
        end else if (acc_sub_i) begin
            res_o = acc_i - prod;
        end else begin
            res_o = acc_i + prod;
        end
    end

endmodule

// File: vmul/vmul_operand_prep.sv
//////////////////////////////////////////////////////////////////////
// operand preparation
// spreads elements over the byte lanes as signed 17-bit operands,
// places the accumulator and builds the result byte mask
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module vmul_operand_prep (
    input  vmul_pkg::vmul_in_t    in_i,
    output vmul_pkg::vmul_lanes_t lanes_o
);

    import vmul_pkg::*;

    // byte to lane operand, sign or zero filled
    function automatic logic [VMUL_LANE_OP_W-1:0] ext_byte(input logic [7:0] b,
                                                           input logic       sgn);
        logic fill;
        fill = sgn & b[7];
        return {{(VMUL_LANE_OP_W-8){fill}}, b};
    endfunction

    // halfword to lane operand, sign or zero filled
    function automatic logic [VMUL_LANE_OP_W-1:0] ext_half(input logic [15:0] h,
                                                           input logic        sgn);
        logic fill;
        fill = sgn & h[15];
        return {{(VMUL_LANE_OP_W-16){fill}}, h};
    endfunction

    logic is_macc;

    assign is_macc = (in_i.ctrl.op == MUL_VMACC);

    //////////////////////////////////////////////////////////////////////
    // lane operands and accumulators

    always_comb begin
        lanes_o.lane_a   = '0;
        lanes_o.lane_b   = '0;
        lanes_o.lane_acc = '0;

        if (in_i.ctrl.eew == EEW_8) begin
            for (int i = 0; i < VMUL_BYTES; i++) begin
                lanes_o.lane_a[i] = ext_byte(in_i.op1[8*i +: 8], in_i.ctrl.op1_signed);
                lanes_o.lane_b[i] = ext_byte(in_i.op2[8*i +: 8], in_i.ctrl.op2_signed);
                if (is_macc) begin
                    lanes_o.lane_acc[i] = {{(VMUL_LANE_RES_W-8){in_i.op3[8*i+7]}},
                                           in_i.op3[8*i +: 8]};
                end
            end
        end else begin
            // halfword k sits in lane 2k, the odd lanes stay zero
            for (int k = 0; k < VMUL_BYTES/2; k++) begin
                lanes_o.lane_a[2*k] = ext_half(in_i.op1[16*k +: 16], in_i.ctrl.op1_signed);
                lanes_o.lane_b[2*k] = ext_half(in_i.op2[16*k +: 16], in_i.ctrl.op2_signed);
                if (is_macc) begin
                    lanes_o.lane_acc[2*k] = {{(VMUL_LANE_RES_W-16){in_i.op3[16*k+15]}},
                                             in_i.op3[16*k +: 16]};
                end
            end
        end
    end

    assign lanes_o.ctrl    = in_i.ctrl;
    assign lanes_o.acc_en  = is_macc;
    assign lanes_o.acc_sub = is_macc & in_i.ctrl.accsub;

    //////////////////////////////////////////////////////////////////////
    // result byte mask

    always_comb begin
        for (int i = 0; i < VMUL_BYTES; i++) begin
            // element mask, then the vector length bound
            lanes_o.res_mask[i] = (in_i.mask[i] | ~in_i.ctrl.masked)
                                & ~in_i.ctrl.vl_part_0
                                & (3'(i) <= in_i.ctrl.vl_part);
        end
    end

endmodule

// File: rtl/vmul_stage.sv
//////////////////////////////////////////////////////////////////////
// pipeline stage
// one valid/ready register slice for an arbitrary payload type
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module vmul_stage #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic async_rst_ni,

    input  logic valid_i,
    output logic ready_o,
    input  T     data_i,

    output logic valid_o,
    input  logic ready_i,
    output T     data_o
);

    logic valid_q;
    T     data_q;

    // accept new data when empty or when the held entry leaves now
    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// File: common/vmul_pkg.sv
//////////////////////////////////////////////////////////////////////
// vmul package
// width constants, operation encodings and stage payloads of the
// SIMD integer multiplier
//////////////////////////////////////////////////////////////////////

package vmul_pkg;

    // data path and lane geometry
    localparam int unsigned VMUL_OP_W       = 64;
    localparam int unsigned VMUL_BYTES      = VMUL_OP_W / 8;
    localparam int unsigned VMUL_LANE_OP_W  = 17;
    localparam int unsigned VMUL_LANE_RES_W = 33;

    typedef enum logic [1:0] {
        MUL_VMUL  = 2'd0,
        MUL_VMULH = 2'd1,
        MUL_VMACC = 2'd2
    } vmul_op_e;

    typedef enum logic {
        EEW_8  = 1'b0,
        EEW_16 = 1'b1
    } vmul_eew_e;

    // control word, carried through every stage
    typedef struct packed {
        vmul_op_e    op;
        vmul_eew_e   eew;
        logic        op1_signed;
        logic        op2_signed;
        logic        accsub;
        logic        masked;
        logic        vl_part_0;
        logic [2:0]  vl_part;
        logic [7:0]  tag;
    } vmul_ctrl_t;

    typedef struct packed {
        vmul_ctrl_t                  ctrl;
        logic [VMUL_OP_W-1:0]        op1;
        logic [VMUL_OP_W-1:0]        op2;
        logic [VMUL_OP_W-1:0]        op3;
        logic [VMUL_BYTES-1:0]       mask;
    } vmul_in_t;

    typedef struct packed {
        vmul_ctrl_t                                     ctrl;
        logic [VMUL_BYTES-1:0][VMUL_LANE_OP_W-1:0]      lane_a;
        logic [VMUL_BYTES-1:0][VMUL_LANE_OP_W-1:0]      lane_b;
        logic [VMUL_BYTES-1:0][VMUL_LANE_RES_W-1:0]     lane_acc;
        logic                                           acc_en;
        logic                                           acc_sub;
        logic [VMUL_BYTES-1:0]                          res_mask;
    } vmul_lanes_t;

    typedef struct packed {
        vmul_ctrl_t                                     ctrl;
        logic [VMUL_BYTES-1:0][VMUL_LANE_RES_W-1:0]     prod;
        logic [VMUL_BYTES-1:0]                          res_mask;
    } vmul_prod_t;

    typedef struct packed {
        vmul_ctrl_t                  ctrl;
        logic [VMUL_OP_W-1:0]        res;
        logic [VMUL_BYTES-1:0]       mask;
    } vmul_out_t;

endpackage
